/* simd_alu.f */
simd_alu_pkg.sv
simd_alu_issue.sv
simd_add_logic.sv
simd_lane_shift.sv
simd_lane_mult.sv
simd_alu_writeback.sv
simd_alu.sv
simd_alu_checker.sv
tb_simd_alu.sv

/* tb_simd_alu.sv */
`timescale 1ns/1ps

module tb_simd_alu import simd_alu_pkg::*; ();

	localparam int n_rand = 4;
	localparam int n_pipe = 20;
	// Items sent by all tests together
	localparam int n_items = 5 * 4 * n_rand + 2 * 4 * n_rand + 12 + 4 * 4 * n_rand + 8
		+ 2 * 3 * n_rand + 7 + 2 * n_pipe;
	localparam int margin_cycles = 2 * n_pipe + 100;

	logic        clk;
	logic        rst;
	logic        in_valid;
	logic [5:0]  opcode;
	logic [5:0]  func;
	lane_width_t width;
	simd_word_t  src_a;
	simd_word_t  src_b;
	logic        out_valid;
	simd_word_t  result;
	int          error_count;
	int          check_count;
	int          pending;
	int          test_checks;
	int          test_errors;
	logic [31:0] lfsr_state;

	logic [63:0] lane_one [4] = '{64'h0101_0101_0101_0101, 64'h0001_0001_0001_0001,
		64'h0000_0001_0000_0001, 64'h0000_0000_0000_0001};
	logic [63:0] lane_top [4] = '{64'h8080_8080_8080_8080, 64'h8000_8000_8000_8000,
		64'h8000_0000_8000_0000, 64'h8000_0000_0000_0000};
	logic [5:0]  bit_fns [5] = '{fn_vand, fn_vor, fn_vxor, fn_vnot, fn_vmov};
	logic [5:0]  shift_fns [4] = '{fn_vsll, fn_vsrl, fn_vsra, fn_vrtth};
	logic [5:0]  all_fns [13] = '{fn_vand, fn_vor, fn_vxor, fn_vnot, fn_vmov, fn_vadd,
		fn_vsub, fn_vmuleu, fn_vmulou, fn_vsll, fn_vsrl, fn_vsra, fn_vrtth};

	simd_alu dut0 (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.opcode    (opcode),
		.func      (func),
		.width     (width),
		.src_a     (src_a),
		.src_b     (src_b),
		.out_valid (out_valid),
		.result    (result)
	);

	simd_alu_checker checker0 (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.opcode      (opcode),
		.func        (func),
		.width       (width),
		.src_a       (src_a),
		.src_b       (src_b),
		.out_valid   (out_valid),
		.result      (result),
		.error_count (error_count),
		.check_count (check_count),
		.pending     (pending)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		#((n_items + margin_cycles) * 20);
		$display("Timeout: the run did not finish within %0d cycles", n_items + margin_cycles);
		$display("Done: errors found");
		$finish;
	end

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit
	task automatic rand_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[62:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Holds the item for exactly one rising edge
	task automatic send(logic [5:0] opc, logic [5:0] fn, lane_width_t wd,
		logic [63:0] a, logic [63:0] b);
		in_valid = 1'b1;
		opcode = opc;
		func = fn;
		width = wd;
		src_a.d = a;
		src_b.d = b;
		@(posedge clk);
		#2;
		in_valid = 1'b0;
	endtask

	task automatic send_rand(logic [5:0] fn, lane_width_t wd);
		logic [63:0] a;
		logic [63:0] b;
		rand_bits(64, a);
		rand_bits(64, b);
		send(op_r_alu, fn, wd, a, b);
	endtask

	task automatic idle(int n);
		in_valid = 1'b0;
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic start_test();
		test_checks = check_count;
		test_errors = error_count;
	endtask

	task automatic finish_test(input string name);
		while (pending != 0) begin
			@(posedge clk);
			#2;
		end
		idle(1);
		$display("Test %-9s %0d checks, %0d errors", name, check_count - test_checks,
			error_count - test_errors);
	endtask

	initial begin
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] r;
		rst = 1'b1;
		in_valid = 1'b0;
		opcode = '0;
		func = '0;
		width = w8;
		src_a = '0;
		src_b = '0;
		lfsr_state = 32'h95fe_6b92;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;

		start_test();
		idle(3);
		finish_test("reset");

		start_test();
		for (int f = 0; f < 5; f++)
			for (int w = 0; w < 4; w++)
				repeat (n_rand) send_rand(bit_fns[f], lane_width_t'(w));
		finish_test("bitwise");

		start_test();
		for (int w = 0; w < 4; w++) begin
			repeat (n_rand) send_rand(fn_vadd, lane_width_t'(w));
			repeat (n_rand) send_rand(fn_vsub, lane_width_t'(w));
			// Carry and borrow right at each lane border
			send(op_r_alu, fn_vadd, lane_width_t'(w), '1, lane_one[w]);
			send(op_r_alu, fn_vadd, lane_width_t'(w), '1, 64'h1);
			send(op_r_alu, fn_vsub, lane_width_t'(w), '0, lane_one[w]);
		end
		finish_test("addsub");

		start_test();
		for (int f = 0; f < 4; f++)
			for (int w = 0; w < 4; w++)
				repeat (n_rand) send_rand(shift_fns[f], lane_width_t'(w));
		for (int w = 0; w < 4; w++) begin
			repeat (2) begin
				rand_bits(64, a);
				rand_bits(64, b);
				send(op_r_alu, fn_vsra, lane_width_t'(w), a | lane_top[w], b);
			end
		end
		finish_test("shift");

		start_test();
		for (int w = 0; w < 3; w++) begin
			repeat (n_rand) send_rand(fn_vmuleu, lane_width_t'(w));
			repeat (n_rand) send_rand(fn_vmulou, lane_width_t'(w));
		end
		rand_bits(64, a);
		rand_bits(64, b);
		// All of these must come back as zero
		send(6'b000000, fn_vadd, w8, a, b);
		send(6'b101011, fn_vand, w16, a, b);
		send(op_r_alu, 6'h00, w32, a, b);
		send(op_r_alu, 6'h0e, w8, a, b);
		send(op_r_alu, 6'h3f, w64, a, b);
		send(op_r_alu, fn_vmuleu, w64, a, b);
		send(op_r_alu, fn_vmulou, w64, a, b);
		finish_test("multiply");

		start_test();
		for (int i = 0; i < n_pipe; i++) begin
			rand_bits(4, r);
			rand_bits(2, b);
			send_rand(all_fns[r % 13], lane_width_t'(b[1:0]));
		end
		for (int i = 0; i < n_pipe; i++) begin
			rand_bits(4, r);
			rand_bits(2, b);
			send_rand(all_fns[r % 13], lane_width_t'(b[1:0]));
			rand_bits(2, r);
			idle(int'(r % 3));
		end
		finish_test("pipeline");

		$display("Total %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* simd_alu_checker.sv */
`timescale 1ns/1ps

module simd_alu_checker import simd_alu_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        in_valid,
	input  logic [5:0]  opcode,
	input  logic [5:0]  func,
	input  lane_width_t width,
	input  simd_word_t  src_a,
	input  simd_word_t  src_b,
	input  logic        out_valid,
	input  simd_word_t  result,
	output int          error_count,
	output int          check_count,
	output int          pending
);

	typedef struct packed {
		logic [5:0]  opcode;
		logic [5:0]  func;
		logic [1:0]  width;
		logic [63:0] a;
		logic [63:0] b;
	} item_t;

	item_t       q[$];
	logic [1:0]  hist;
	logic [63:0] last_result = '0;
	int          pushed_cnt;
	int          popped_cnt;

	assign pending = pushed_cnt - popped_cnt;

	// Expected word from the instruction rules, lane 0 in the top bits
	function automatic logic [63:0] expected_word(logic [5:0] opc, logic [5:0] fn,
		logic [1:0] wd, logic [63:0] a, logic [63:0] b);
		int          lw;
		int          n;
		int          sh;
		int          amt;
		int          j;
		logic [63:0] mask;
		logic [63:0] x;
		logic [63:0] y;
		logic [63:0] r;
		logic [63:0] res;
		res = '0;
		lw = 8 << wd;
		n = 64 / lw;
		mask = (lw == 64) ? '1 : ((64'd1 << lw) - 64'd1);
		if (opc != op_r_alu)
			return '0;
		case (fn)
			fn_vand: return a & b;
			fn_vor:  return a | b;
			fn_vxor: return a ^ b;
			fn_vnot: return ~a;
			fn_vmov: return a;
			fn_vadd, fn_vsub, fn_vsll, fn_vsrl, fn_vsra, fn_vrtth: begin
				for (int i = 0; i < n; i++) begin
					sh = (n - 1 - i) * lw;
					x = (a >> sh) & mask;
					y = (b >> sh) & mask;
					amt = y[5:0] & (lw - 1);
					case (fn)
						fn_vadd: r = x + y;
						fn_vsub: r = x - y;
						fn_vsll: r = x << amt;
						fn_vsrl: r = x >> amt;
						// Vacated top bits take the lane sign
						fn_vsra: r = x[lw-1] ? ((x >> amt) | (mask & ~(mask >> amt))) : (x >> amt);
						// Low half moves up, high half moves down
						default: r = ((x & (mask >> (lw / 2))) << (lw / 2)) | (x >> (lw / 2));
					endcase
					res = res | ((r & mask) << sh);
				end
				return res;
			end
			fn_vmuleu, fn_vmulou: begin
				if (lw == 64)
					return '0;
				for (int k = 0; k < n / 2; k++) begin
					j = 2 * k + ((fn == fn_vmulou) ? 1 : 0);
					x = (a >> ((n - 1 - j) * lw)) & mask;
					y = (b >> ((n - 1 - j) * lw)) & mask;
					res = res | ((x * y) << ((n / 2 - 1 - k) * 2 * lw));
				end
				return res;
			end
			default: return '0;
		endcase
	endfunction

	function automatic string op_text(item_t it);
		return $sformatf("opcode %b func %b lanes %0d", it.opcode, it.func, 8 << it.width);
	endfunction

	// Input side sampled where the TB drove it a full cycle earlier
	always @(posedge clk) begin
		item_t it;
		if (rst) begin
			hist <= '0;
		end else begin
			hist <= {hist[0], in_valid};
			if (in_valid) begin
				it.opcode = opcode;
				it.func = func;
				it.width = width;
				it.a = src_a.d;
				it.b = src_b.d;
				q.push_back(it);
				pushed_cnt++;
			end
		end
	end

	// Outputs are checked mid cycle
	always @(negedge clk) begin
		item_t       it;
		logic [63:0] exp;
		if (!rst) begin
			if (out_valid && hist[1] && q.size() != 0) begin
				it = q.pop_front();
				popped_cnt++;
				exp = expected_word(it.opcode, it.func, it.width, it.a, it.b);
				check_count++;
				if (result.d !== exp) begin
					$display("Mismatch at %0t: %s a %h b %h expected %h got %h", $time,
						op_text(it), it.a, it.b, exp, result.d);
					error_count++;
				end
				last_result = result.d;
			end else if (out_valid) begin
				$display("Error at %0t: out_valid is high but no item went in two cycles before",
					$time);
				error_count++;
			end else if (hist[1]) begin
				$display("Error at %0t: out_valid stayed low two cycles after in_valid", $time);
				error_count++;
				if (q.size() != 0) begin
					it = q.pop_front();
					popped_cnt++;
				end
			end else begin
				// Zero after reset, then held across gaps
				check_count++;
				if (result.d !== last_result) begin
					$display("Mismatch at %0t: result changed without out_valid, expected %h got %h",
						$time, last_result, result.d);
					error_count++;
				end
			end
		end
	end

endmodule

/* simd_alu.sv */
`timescale 1ns/1ps

module simd_alu import simd_alu_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        in_valid,
	input  logic [5:0]  opcode,
	input  logic [5:0]  func,
	input  lane_width_t width,
	input  simd_word_t  src_a,
	input  simd_word_t  src_b,
	output logic        out_valid,
	output simd_word_t  result
);

	logic        iss_valid;
	alu_op_t     iss_op;
	lane_width_t iss_width;
	simd_word_t  iss_a;
	simd_word_t  iss_b;
	simd_word_t  addlog_res;
	simd_word_t  shift_res;
	simd_word_t  mult_res;

	// Stage 1 register
	simd_alu_issue issue0 (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.opcode    (opcode),
		.func      (func),
		.width     (width),
		.src_a     (src_a),
		.src_b     (src_b),
		.iss_valid (iss_valid),
		.iss_op    (iss_op),
		.iss_width (iss_width),
		.iss_a     (iss_a),
		.iss_b     (iss_b)
	);

	// Combinational lane units
	simd_add_logic addlog0 (
		.iss_op     (iss_op),
		.iss_width  (iss_width),
		.iss_a      (iss_a),
		.iss_b      (iss_b),
		.addlog_res (addlog_res)
	);

	simd_lane_shift shift0 (
		.iss_op    (iss_op),
		.iss_width (iss_width),
		.iss_a     (iss_a),
		.iss_b     (iss_b),
		.shift_res (shift_res)
	);

	simd_lane_mult mult0 (
		.iss_op    (iss_op),
		.iss_width (iss_width),
		.iss_a     (iss_a),
		.iss_b     (iss_b),
		.mult_res  (mult_res)
	);

	// Stage 2 register
	simd_alu_writeback wb0 (
		.clk        (clk),
		.rst        (rst),
		.iss_valid  (iss_valid),
		.iss_op     (iss_op),
		.addlog_res (addlog_res),
		.shift_res  (shift_res),
		.mult_res   (mult_res),
		.out_valid  (out_valid),
		.result     (result)
	);

endmodule

/* simd_alu_writeback.sv */
`timescale 1ns/1ps

module simd_alu_writeback import simd_alu_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       iss_valid,
	input  alu_op_t    iss_op,
	input  simd_word_t addlog_res,
	input  simd_word_t shift_res,
	input  simd_word_t mult_res,
	output logic       out_valid,
	output simd_word_t result
);

	simd_word_t sel_res;

	// Result of the unit that owns the operation
	always_comb begin
		case (unit_of(iss_op))
			unit_addlog: sel_res = addlog_res;
			unit_shift:  sel_res = shift_res;
			unit_mult:   sel_res = mult_res;
			default:     sel_res = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			result <= '0;
		end else begin
			out_valid <= iss_valid;
			// Hold last result across gaps
			if (iss_valid) begin
				result <= sel_res;
			end
		end
	end

endmodule

/* simd_lane_mult.sv */
`timescale 1ns/1ps

module simd_lane_mult import simd_alu_pkg::*; (
	input  alu_op_t     iss_op,
	input  lane_width_t iss_width,
	input  simd_word_t  iss_a,
	input  simd_word_t  iss_b,
	output simd_word_t  mult_res
);

	logic is_mult;
	logic odd;

	assign is_mult = (iss_op == op_mule) || (iss_op == op_mulo);
	// Odd picks input lane 2k+1, even picks lane 2k
	assign odd = (iss_op == op_mulo);

	// Output lane k is twice as wide as the input lanes
	always_comb begin
		mult_res = '0;
		if (is_mult) begin
			case (iss_width)
				w8: begin
					for (int k = 0; k < word_w / 16; k++) begin
						mult_res.h[k] = iss_a.b[2*k + int'(odd)] * iss_b.b[2*k + int'(odd)];
					end
				end
				w16: begin
					for (int k = 0; k < word_w / 32; k++) begin
						mult_res.w[k] = iss_a.h[2*k + int'(odd)] * iss_b.h[2*k + int'(odd)];
					end
				end
				w32: begin
					mult_res.d = iss_a.w[int'(odd)] * iss_b.w[int'(odd)];
				end
				// 64-bit lanes have no wider product lane
				w64: mult_res = '0;
			endcase
		end
	end

endmodule

/* simd_lane_shift.sv */
`timescale 1ns/1ps

module simd_lane_shift import simd_alu_pkg::*; (
	input  alu_op_t     iss_op,
	input  lane_width_t iss_width,
	input  simd_word_t  iss_a,
	input  simd_word_t  iss_b,
	output simd_word_t  shift_res
);

	// One lane of lw bits, zero extended in x and y
	// Caller keeps only the low lw bits of the return value
	function automatic logic [word_w-1:0] lane_op(
		alu_op_t           op,
		logic [word_w-1:0] x,
		logic [word_w-1:0] y,
		int                lw
	);
		logic [5:0]        amt;
		logic [word_w-1:0] hi_mask;
		logic [word_w-1:0] sx;
		// Amount is log2(lw) low bits of the b lane
		amt = y[5:0] & 6'(lw - 1);
		hi_mask = ~((word_w'(1) << lw) - word_w'(1));
		// Sign extended copy for the arithmetic shift
		sx = x[lw-1] ? (x | hi_mask) : x;
		case (op)
			op_sll:  lane_op = x << amt;
			op_srl:  lane_op = x >> amt;
			op_sra:  lane_op = $signed(sx) >>> amt;
			op_rot:  lane_op = (x >> (lw / 2)) | (x << (lw / 2));
			default: lane_op = '0;
		endcase
	endfunction

	always_comb begin
		shift_res = '0;
		case (iss_width)
			w8: begin
				for (int i = 0; i < word_w / 8; i++) begin
					shift_res.b[i] = 8'(lane_op(iss_op, word_w'(iss_a.b[i]),
						word_w'(iss_b.b[i]), 8));
				end
			end
			w16: begin
				for (int i = 0; i < word_w / 16; i++) begin
					shift_res.h[i] = 16'(lane_op(iss_op, word_w'(iss_a.h[i]),
						word_w'(iss_b.h[i]), 16));
				end
			end
			w32: begin
				for (int i = 0; i < word_w / 32; i++) begin
					shift_res.w[i] = 32'(lane_op(iss_op, word_w'(iss_a.w[i]),
						word_w'(iss_b.w[i]), 32));
				end
			end
			w64: shift_res.d = lane_op(iss_op, iss_a.d, iss_b.d, word_w);
		endcase
	end

endmodule

/* simd_add_logic.sv */
`timescale 1ns/1ps

module simd_add_logic import simd_alu_pkg::*; (
	input  alu_op_t     iss_op,
	input  lane_width_t iss_width,
	input  simd_word_t  iss_a,
	input  simd_word_t  iss_b,
	output simd_word_t  addlog_res
);

	logic       is_sub;
	simd_word_t opnd_b;
	simd_word_t arith;

	// Subtract is a plus inverted b plus one in every lane
	assign is_sub = (iss_op == op_sub);
	assign opnd_b.d = is_sub ? ~iss_b.d : iss_b.d;

	// Carries stop at the lane border
	always_comb begin
		arith = '0;
		case (iss_width)
			w8: begin
				for (int i = 0; i < word_w / 8; i++) begin
					arith.b[i] = iss_a.b[i] + opnd_b.b[i] + 8'(is_sub);
				end
			end
			w16: begin
				for (int i = 0; i < word_w / 16; i++) begin
					arith.h[i] = iss_a.h[i] + opnd_b.h[i] + 16'(is_sub);
				end
			end
			w32: begin
				for (int i = 0; i < word_w / 32; i++) begin
					arith.w[i] = iss_a.w[i] + opnd_b.w[i] + 32'(is_sub);
				end
			end
			w64: arith.d = iss_a.d + opnd_b.d + word_w'(is_sub);
		endcase
	end

	// Bitwise operations are width independent
	always_comb begin
		case (iss_op)
			op_and:         addlog_res.d = iss_a.d & iss_b.d;
			op_or:          addlog_res.d = iss_a.d | iss_b.d;
			op_xor:         addlog_res.d = iss_a.d ^ iss_b.d;
			op_not:         addlog_res.d = ~iss_a.d;
			op_mov:         addlog_res = iss_a;
			op_add, op_sub: addlog_res = arith;
			default:        addlog_res = '0;
		endcase
	end

endmodule

/* simd_alu_issue.sv */
`timescale 1ns/1ps

module simd_alu_issue import simd_alu_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        in_valid,
	input  logic [5:0]  opcode,
	input  logic [5:0]  func,
	input  lane_width_t width,
	input  simd_word_t  src_a,
	input  simd_word_t  src_b,
	output logic        iss_valid,
	output alu_op_t     iss_op,
	output lane_width_t iss_width,
	output simd_word_t  iss_a,
	output simd_word_t  iss_b
);

	alu_op_t dec_op;

	// Opcode and function to internal operation
	always_comb begin
		dec_op = op_zero;
		if (opcode == op_r_alu) begin
			case (func)
				fn_vand:   dec_op = op_and;
				fn_vor:    dec_op = op_or;
				fn_vxor:   dec_op = op_xor;
				fn_vnot:   dec_op = op_not;
				fn_vmov:   dec_op = op_mov;
				fn_vadd:   dec_op = op_add;
				fn_vsub:   dec_op = op_sub;
				// No 64x64 products
				fn_vmuleu: dec_op = (width == w64) ? op_zero : op_mule;
				fn_vmulou: dec_op = (width == w64) ? op_zero : op_mulo;
				fn_vsll:   dec_op = op_sll;
				fn_vsrl:   dec_op = op_srl;
				fn_vsra:   dec_op = op_sra;
				fn_vrtth:  dec_op = op_rot;
				default:   dec_op = op_zero;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			iss_valid <= 1'b0;
			iss_op <= op_zero;
		end else begin
			iss_valid <= in_valid;
			if (in_valid) begin
				iss_op <= dec_op;
			end
		end
	end

	// Operand capture
	always_ff @(posedge clk) begin
		if (in_valid) begin
			iss_width <= width;
			iss_a <= src_a;
			iss_b <= src_b;
		end
	end

endmodule

/* simd_alu_pkg.sv */
package simd_alu_pkg;

	// Datapath width
	localparam int word_w = 64;

	// Major opcode for register ALU instructions
	localparam logic [5:0] op_r_alu = 6'b101010;

	// Function codes
	localparam logic [5:0] fn_vand   = 6'b000001;
	localparam logic [5:0] fn_vor    = 6'b000010;
	localparam logic [5:0] fn_vxor   = 6'b000011;
	localparam logic [5:0] fn_vnot   = 6'b000100;
	localparam logic [5:0] fn_vmov   = 6'b000101;
	localparam logic [5:0] fn_vadd   = 6'b000110;
	localparam logic [5:0] fn_vsub   = 6'b000111;
	localparam logic [5:0] fn_vmuleu = 6'b001000;
	localparam logic [5:0] fn_vmulou = 6'b001001;
	localparam logic [5:0] fn_vsll   = 6'b001010;
	localparam logic [5:0] fn_vsrl   = 6'b001011;
	localparam logic [5:0] fn_vsra   = 6'b001100;
	localparam logic [5:0] fn_vrtth  = 6'b001101;

	typedef enum logic [1:0] {
		w8  = 2'd0,
		w16 = 2'd1,
		w32 = 2'd2,
		w64 = 2'd3
	} lane_width_t;

	// Lane 0 is the most significant lane in every view
	typedef union packed {
		logic [0:word_w/8-1][7:0]   b;
		logic [0:word_w/16-1][15:0] h;
		logic [0:word_w/32-1][31:0] w;
		logic [word_w-1:0]          d;
	} simd_word_t;

	typedef enum logic [3:0] {
		op_zero, op_and, op_or, op_xor, op_not, op_mov, op_add, op_sub,
		op_mule, op_mulo, op_sll, op_srl, op_sra, op_rot
	} alu_op_t;

	typedef enum logic [1:0] {
		unit_none, unit_addlog, unit_shift, unit_mult
	} alu_unit_t;

	// Which execution unit produces the result of an operation
	function automatic alu_unit_t unit_of(alu_op_t op);
		case (op)
			op_and, op_or, op_xor, op_not, op_mov, op_add, op_sub: return unit_addlog;
			op_sll, op_srl, op_sra, op_rot: return unit_shift;
			op_mule, op_mulo: return unit_mult;
			default: return unit_none;
		endcase
	endfunction

endpackage
